//--- project.f
+incdir+source
source/noc_pkg.sv
source/xy_route.sv
source/input_port.sv
source/output_arbiter.sv
source/router_top.sv
tests/router_tb.sv

//--- source/input_port.sv
`timescale 1ns/10ps

module input_port
(
	input logic clk,
	input logic rst_n,
	input noc_pkg::coord_t node,
	input logic in_req,
	input noc_pkg::flit_t in_flit,
	output logic in_ack,
	output noc_pkg::port_vec_t route_req,
	output noc_pkg::flit_t hold_flit,
	input logic sent
);
	import noc_pkg::*;

	// receiver states
	typedef enum logic [1:0]
	{
		st_idle,
		st_hold,
		st_release
	} in_state_t;

	in_state_t state;

	// destination field of the held flit
	coord_t hold_dest;
	// one-hot output for the held flit
	port_vec_t route_sel;

	////////////////////
	// four-phase receive
	////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			in_ack <= 1'b0;
		end
		else
		begin
			case (state)
				// new flit offered
				st_idle:
				begin
					if (in_req)
					begin
						state <= st_hold;
						in_ack <= 1'b1;
					end
				end
				// waiting on the output side, ack stays up
				st_hold:
				begin
					if (sent)
					begin
						// sender already dropped req
						if (!in_req)
						begin
							state <= st_idle;
							in_ack <= 1'b0;
						end
						else
							state <= st_release;
					end
				end
				// flit gone, wait for req low
				st_release:
				begin
					if (!in_req)
					begin
						state <= st_idle;
						in_ack <= 1'b0;
					end
				end
				default:
				begin
					state <= st_idle;
					in_ack <= 1'b0;
				end
			endcase
		end
	end

	// capture on the accepting cycle only
	always_ff @(posedge clk)
	begin
		if (state == st_idle && in_req)
			hold_flit <= in_flit;
	end

	////////////////////
	// route of the held flit
	////////////////////
	assign hold_dest = hold_flit[$bits(flit_t)-1 -: $bits(coord_t)];

	xy_route xy_route_i
	(
		.node(node),
		.dest(hold_dest),
		.port_sel(route_sel)
	);

	// request only while a flit is waiting
	assign route_req = (state == st_hold) ? route_sel : '0;

endmodule

//--- source/noc_cfg.svh
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

////////////////////
// mesh geometry
////////////////////

// x coordinate bits, 4 columns
`define NOC_X_W 2
// y coordinate bits, 4 rows
`define NOC_Y_W 2

////////////////////
// flit and router size
////////////////////

// payload bits below the destination field
`define NOC_PAYLOAD_W 12
// local plus four neighbours
`define NOC_PORTS 5

`endif

//--- source/noc_pkg.sv
package noc_pkg;

`include "noc_cfg.svh"

	////////////////////
	// widths with a meaning
	////////////////////

	// node or destination, x in the high bits, y in the low bits
	typedef logic [`NOC_X_W+`NOC_Y_W-1:0] coord_t;

	// single-flit packet, destination on top, payload below
	typedef logic [`NOC_X_W+`NOC_Y_W+`NOC_PAYLOAD_W-1:0] flit_t;

	// port number
	typedef logic [2:0] port_idx_t;

	// one bit per port, indexed by the constants below
	typedef logic [`NOC_PORTS-1:0] port_vec_t;

	////////////////////
	// port numbering
	////////////////////

	// bit order of port_vec_t
	parameter port_idx_t port_local = 3'd0;
	parameter port_idx_t port_east = 3'd1;
	parameter port_idx_t port_north = 3'd2;
	parameter port_idx_t port_west = 3'd3;
	parameter port_idx_t port_south = 3'd4;

endpackage

//--- source/output_arbiter.sv
`timescale 1ns/10ps

`include "noc_cfg.svh"

module output_arbiter
(
	input logic clk,
	input logic rst_n,
	input noc_pkg::port_vec_t req,
	input noc_pkg::flit_t flits [`NOC_PORTS],
	output noc_pkg::port_vec_t sent,
	output logic out_req,
	output noc_pkg::flit_t out_flit,
	input logic out_ack
);
	import noc_pkg::*;

	// sender states
	typedef enum logic [1:0]
	{
		st_idle,
		st_send,
		st_wait_low
	} out_state_t;

	out_state_t state;

	// last granted input
	port_idx_t rr_ptr;
	// input owning the current transfer
	port_idx_t grant;
	// round-robin result
	logic pick_valid;
	port_idx_t pick_idx;
	// pointer plus offset, wrapped
	logic [3:0] rr_sum;

	////////////////////
	// round-robin pick
	////////////////////
	// walk offsets from far to near, nearest requester wins
	always_comb
	begin
		pick_valid = 1'b0;
		pick_idx = rr_ptr;
		rr_sum = '0;
		for (int k = `NOC_PORTS; k >= 1; k--)
		begin
			rr_sum = {1'b0, rr_ptr} + 4'(k);
			if (rr_sum >= 4'(`NOC_PORTS))
				rr_sum = rr_sum - 4'(`NOC_PORTS);
			if (req[rr_sum[2:0]])
			begin
				pick_valid = 1'b1;
				pick_idx = rr_sum[2:0];
			end
		end
	end

	////////////////////
	// four-phase send
	////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			rr_ptr <= port_local;
			grant <= port_local;
			out_req <= 1'b0;
			sent <= '0;
		end
		else
		begin
			// sent is a single-cycle pulse
			sent <= '0;
			case (state)
				st_idle:
				begin
					if (pick_valid)
					begin
						grant <= pick_idx;
						rr_ptr <= pick_idx;
						out_req <= 1'b1;
						state <= st_send;
					end
				end
				// downstream took it, release the input
				st_send:
				begin
					if (out_ack)
					begin
						out_req <= 1'b0;
						sent[grant] <= 1'b1;
						state <= st_wait_low;
					end
				end
				st_wait_low:
				begin
					if (!out_ack)
						state <= st_idle;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// flit latched with the grant
	always_ff @(posedge clk)
	begin
		if (state == st_idle && pick_valid)
			out_flit <= flits[pick_idx];
	end

endmodule

//--- source/router_top.sv
`timescale 1ns/10ps

`include "noc_cfg.svh"

module router_top
(
	input logic clk,
	input logic rst_n,
	input noc_pkg::coord_t node,
	input noc_pkg::port_vec_t in_req,
	input noc_pkg::flit_t in_flit [`NOC_PORTS],
	output noc_pkg::port_vec_t in_ack,
	output noc_pkg::port_vec_t out_req,
	output noc_pkg::flit_t out_flit [`NOC_PORTS],
	input noc_pkg::port_vec_t out_ack
);
	import noc_pkg::*;

	// per input, the output it wants
	port_vec_t route_req [`NOC_PORTS];
	// per input, the flit it holds
	flit_t hold_flit [`NOC_PORTS];
	// per output, which inputs want it
	port_vec_t arb_req [`NOC_PORTS];
	// per output, which input it just released
	port_vec_t arb_sent [`NOC_PORTS];
	// per input, release bits from every output
	port_vec_t sent_col [`NOC_PORTS];
	// per input, combined release
	port_vec_t in_sent;

	genvar i, o;

	generate
		////////////////////
		// input side
		////////////////////
		for (i = 0; i < `NOC_PORTS; i = i + 1)
		begin : g_in
			input_port input_port_i
			(
				.clk(clk),
				.rst_n(rst_n),
				.node(node),
				.in_req(in_req[i]),
				.in_flit(in_flit[i]),
				.in_ack(in_ack[i]),
				.route_req(route_req[i]),
				.hold_flit(hold_flit[i]),
				.sent(in_sent[i])
			);
		end

		////////////////////
		// output side
		////////////////////
		// every arbiter sees all held flits
		for (o = 0; o < `NOC_PORTS; o = o + 1)
		begin : g_out
			output_arbiter output_arbiter_i
			(
				.clk(clk),
				.rst_n(rst_n),
				.req(arb_req[o]),
				.flits(hold_flit),
				.sent(arb_sent[o]),
				.out_req(out_req[o]),
				.out_flit(out_flit[o]),
				.out_ack(out_ack[o])
			);
		end

		////////////////////
		// crossbar transpose
		////////////////////
		for (i = 0; i < `NOC_PORTS; i = i + 1)
		begin : g_xpose_in
			for (o = 0; o < `NOC_PORTS; o = o + 1)
			begin : g_xpose_out
				// request bit o of input i to arbiter o
				assign arb_req[o][i] = route_req[i][o];
				// release bit i of arbiter o back to input i
				assign sent_col[i][o] = arb_sent[o][i];
			end
			// one route bit per input, so at most one arbiter fires
			assign in_sent[i] = |sent_col[i];
		end
	endgenerate

endmodule

//--- source/xy_route.sv
`timescale 1ns/10ps

`include "noc_cfg.svh"

module xy_route
(
	input noc_pkg::coord_t node,
	input noc_pkg::coord_t dest,
	output noc_pkg::port_vec_t port_sel
);
	import noc_pkg::*;

	// coordinate fields split out
	logic [`NOC_X_W-1:0] node_x;
	logic [`NOC_Y_W-1:0] node_y;
	logic [`NOC_X_W-1:0] dest_x;
	logic [`NOC_Y_W-1:0] dest_y;

	// differences, one bit wider for the sign
	logic signed [`NOC_X_W:0] xdiff;
	logic signed [`NOC_Y_W:0] ydiff;

	////////////////////
	// field split
	////////////////////
	assign node_x = node[`NOC_X_W+`NOC_Y_W-1 -: `NOC_X_W];
	assign node_y = node[`NOC_Y_W-1:0];
	assign dest_x = dest[`NOC_X_W+`NOC_Y_W-1 -: `NOC_X_W];
	assign dest_y = dest[`NOC_Y_W-1:0];

	// zero-extended before subtracting
	assign xdiff = $signed({1'b0, dest_x}) - $signed({1'b0, node_x});
	assign ydiff = $signed({1'b0, dest_y}) - $signed({1'b0, node_y});

	////////////////////
	// x first, then y
	////////////////////
	always_comb
	begin
		port_sel = '0;
		// still columns to cover
		if (xdiff > 0)
			port_sel[port_east] = 1'b1;
		else if (xdiff < 0)
			port_sel[port_west] = 1'b1;
		// right column, y grows southward
		else if (ydiff > 0)
			port_sel[port_south] = 1'b1;
		else if (ydiff < 0)
			port_sel[port_north] = 1'b1;
		// arrived
		else
			port_sel[port_local] = 1'b1;
	end

endmodule

//--- tests/router_tb.sv
`timescale 1ns/10ps

`include "noc_cfg.svh"

module router_tb;
	import noc_pkg::*;

	// run limit, about 62 flits at well under 60 cycles each
	localparam int max_cycles = 4000;

	logic clk;
	logic rst_n;
	coord_t node;
	port_vec_t in_req;
	flit_t in_flit [`NOC_PORTS];
	port_vec_t in_ack;
	port_vec_t out_req;
	flit_t out_flit [`NOC_PORTS];
	wire [`NOC_PORTS-1:0] out_ack;

	// per-sink ack and stall control
	logic sink_ack [`NOC_PORTS];
	logic stall [`NOC_PORTS];

	// expected flits per (source, output) pair, ring of 64
	flit_t exp_mem [25][64];
	int head [25];
	int tail [25];

	int cycles;
	int unsigned rng;
	coord_t rnd_dest [`NOC_PORTS][8];

	assign out_ack = {sink_ack[4], sink_ack[3], sink_ack[2], sink_ack[1], sink_ack[0]};

	router_top router_top_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.node(node),
		.in_req(in_req),
		.in_flit(in_flit),
		.in_ack(in_ack),
		.out_req(out_req),
		.out_flit(out_flit),
		.out_ack(out_ack)
	);

	////////////////////
	// helpers
	////////////////////
	function automatic int unsigned xorshift(int unsigned x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// expected output, x first then y, south is +y
	function automatic int route_ref(coord_t n, coord_t d);
		int dx;
		int dy;
		dx = int'(d[3:2]) - int'(n[3:2]);
		dy = int'(d[1:0]) - int'(n[1:0]);
		if (dx > 0)
			return port_east;
		if (dx < 0)
			return port_west;
		if (dy > 0)
			return port_south;
		if (dy < 0)
			return port_north;
		return port_local;
	endfunction

	function automatic bit logs_empty();
		for (int i = 0; i < 25; i++)
			if (head[i] != tail[i])
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// four-phase send, flit payload tags the source port and a number
	task automatic send_flit(int p, coord_t d, int k);
		flit_t f;
		int idx;
		f = {d, 3'(p), 9'(k)};
		idx = p * 5 + route_ref(node, d);
		@(negedge clk);
		exp_mem[idx][tail[idx] % 64] = f;
		tail[idx]++;
		in_flit[p] = f;
		in_req[p] = 1'b1;
		do @(negedge clk); while (!in_ack[p]);
		in_req[p] = 1'b0;
		do @(negedge clk); while (in_ack[p]);
	endtask

	task automatic send_burst(int p);
		for (int k = 0; k < 8; k++)
			send_flit(p, rnd_dest[p][k], k);
	endtask

	task automatic drain();
		do @(negedge clk); while (!logs_empty());
		// quiet spell, a repeated flit would still reach a sink here
		repeat (20) @(negedge clk);
	endtask

	////////////////////
	// clock and timeout
	////////////////////
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("timeout: traffic still pending after %0d cycles", max_cycles);
			$display("test failed");
			$fatal(1, "timeout");
		end
	end

	////////////////////
	// output sinks
	////////////////////
	genvar o;
	generate
		for (o = 0; o < `NOC_PORTS; o = o + 1)
		begin : g_sink
			initial
			begin
				int unsigned st;
				int src;
				int idx;
				st = xorshift(99314 + o);
				forever
				begin
					@(negedge clk);
					if (out_req[o] && !stall[o])
					begin
						// source port sits in the payload top bits
						src = int'(out_flit[o][11:9]);
						idx = src * 5 + o;
						if (src > 4 || head[idx] == tail[idx])
						begin
							$display("unexpected flit %h at output %0d", out_flit[o], o);
							$display("test failed");
							$fatal(1, "unexpected flit");
						end
						check($sformatf("out_flit[%0d]", o), out_flit[o],
							exp_mem[idx][head[idx] % 64]);
						head[idx]++;
						// random ack delay 0..3
						st = xorshift(st);
						repeat (st % 4) @(negedge clk);
						sink_ack[o] = 1'b1;
						do @(negedge clk); while (out_req[o]);
						sink_ack[o] = 1'b0;
					end
				end
			end
		end
	endgenerate

	////////////////////
	// main sequence
	////////////////////
	initial
	begin
		node = {2'd1, 2'd2};
		rst_n = 1'b0;
		in_req = '0;
		cycles = 0;
		rng = 99314;
		for (int i = 0; i < `NOC_PORTS; i++)
		begin
			in_flit[i] = '0;
			sink_ack[i] = 1'b0;
			stall[i] = 1'b0;
		end
		for (int i = 0; i < 25; i++)
		begin
			head[i] = 0;
			tail[i] = 0;
		end
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		// idle after reset
		repeat (6)
		begin
			@(negedge clk);
			check("out_req", out_req, 0);
			check("in_ack", in_ack, 0);
		end

		// local input to all 16 nodes
		for (int d = 0; d < 16; d++)
			send_flit(port_local, coord_t'(d), d);
		drain();

		// random traffic on all inputs at once
		for (int p = 0; p < `NOC_PORTS; p++)
			for (int k = 0; k < 8; k++)
			begin
				rng = xorshift(rng);
				rnd_dest[p][k] = coord_t'(rng[7:4]);
			end
		fork
			send_burst(0);
			send_burst(1);
			send_burst(2);
			send_burst(3);
			send_burst(4);
		join
		drain();

		// four neighbours into local
		fork
			send_flit(port_east, node, 1);
			send_flit(port_north, node, 2);
			send_flit(port_west, node, 3);
			send_flit(port_south, node, 4);
		join
		drain();

		// east stalled, two flits queued behind it
		stall[port_east] = 1'b1;
		fork
			begin
				send_flit(port_local, {2'd3, 2'd0}, 10);
				send_flit(port_local, {2'd2, 2'd3}, 11);
			end
			begin
				repeat (5) @(negedge clk);
				repeat (30)
				begin
					@(negedge clk);
					check("in_ack[0]", in_ack[port_local], 1);
					check("out_req[1]", out_req[port_east], 1);
					// first flit parked at the east output
					check("out_flit[1]", out_flit[port_east],
						{2'd3, 2'd0, 3'(port_local), 9'(10)});
				end
				stall[port_east] = 1'b0;
			end
		join
		drain();

		if (logs_empty())
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			$display("flits still expected at end of run");
			$display("test failed");
			$fatal(1, "flits missing");
		end
	end

endmodule
